//--- trace_pkg.sv
// sizes are fixed here; PCs count halfwords and a trace never spans more than num_lanes bundles
package trace_pkg;

        localparam int va_sz      = 32;                 // virtual address width
        localparam int num_lanes  = 4;                  // bundles per trace
        localparam int num_lines  = 8;                  // trace lines
        localparam int line_idx_w = $clog2(num_lines);
        localparam int use_w      = 3;                  // use counter width

        localparam logic [use_w-1:0] use_max  = 3'd7;   // counter saturates here
        localparam logic [use_w-1:0] use_fill = 3'd2;   // floor given to a newly filled line

        typedef logic [va_sz-1:1]     pc_t;             // halfword PC
        typedef logic [num_lanes-1:0] lane_mask_t;
        typedef logic [num_lines-1:0] line_vec_t;

        // how a bundle leaves its pc
        typedef enum logic [1:0] {
                br_none     = 2'd0,                     // falls through
                br_relative = 2'd1,                     // pc + immed
                br_indirect = 2'd2                      // pc_dest
        } branch_kind_e;

        typedef struct packed {
                pc_t          pc;
                logic [31:0]  insn;
                logic [31:0]  immed;
                logic         short_ins;                // compressed instruction
                branch_kind_e kind;
                pc_t          pc_dest;
        } trace_bundle_t;

        typedef struct packed {
                lane_mask_t                     valid;
                trace_bundle_t [num_lanes-1:0]  b;
        } trace_group_t;

        // one-cycle fill request toward the metadata and the bundle array
        typedef struct packed {
                logic       write;
                lane_mask_t lanes;
                pc_t        tag;                        // start pc of the trace
                pc_t        next;                       // pc after the last lane
        } fill_req_t;

        // the top bits of scale pick a timer reload run of 4 to 7 ones with scale[1:0] above it
        function automatic logic [8:0] decay_reload(input logic [3:0] scale);
                logic [8:0] val;
                case (scale[3:2])
                2'b00:   val = {3'b000, scale[1:0], 4'hf};
                2'b01:   val = {2'b00, scale[1:0], 5'h1f};
                2'b10:   val = {1'b0, scale[1:0], 6'h3f};
                default: val = {scale[1:0], 7'h7f};
                endcase
                return val;
        endfunction

endpackage

//--- trace_fill_ctrl.sv
// combinational only; a group is taken whole as a new line or dropped, partial merges are not done
`timescale 1ns/10ps

module trace_fill_ctrl import trace_pkg::*; (
        input  trace_group_t trace_in,
        input  lane_mask_t   will_trap,
        input  logic         flush,
        input  logic         start_hit,                 // start pc already cached
        input  logic         free_valid,                // a line is free
        output pc_t          start_pc,
        output fill_req_t    fill
);

        pc_t        lane_next [num_lanes];
        pc_t        last_next;
        lane_mask_t valid;
        logic       contiguous;
        logic       trapped;
        logic       clean;

        assign valid    = trace_in.valid;
        assign start_pc = trace_in.b[0].pc;

        // valid lanes must form a run starting at lane 0
        assign contiguous = ((valid + lane_mask_t'(1)) & valid) == '0;
        assign trapped    = |(will_trap & valid);
        assign clean      = valid[0] && contiguous && !trapped && !flush;

        // where each lane would continue
        always_comb begin
                for (int i = 0; i < num_lanes; i++) begin
                        case (trace_in.b[i].kind)
                        br_relative: lane_next[i] = trace_in.b[i].pc +
                                                    pc_t'(trace_in.b[i].immed[va_sz-2:0]);
                        br_indirect: lane_next[i] = trace_in.b[i].pc_dest;
                        default:     lane_next[i] = trace_in.b[i].pc +
                                                    {{(va_sz-3){1'b0}},
                                                     ~trace_in.b[i].short_ins,
                                                     trace_in.b[i].short_ins};
                        endcase
                end
        end

        // pick the highest valid lane
        always_comb begin
                last_next = lane_next[0];
                for (int i = 1; i < num_lanes; i++) begin
                        if (valid[i])
                                last_next = lane_next[i];
                end
        end

        always_comb begin
                fill.write = clean && !start_hit && free_valid;
                fill.lanes = valid;
                fill.tag   = start_pc;
                fill.next  = last_next;
        end

endmodule

//--- trace_line_meta.sv
// lookup is combinational over all lines; clear, or trace_enable low, wipes masks and counters at the next edge
`timescale 1ns/10ps

module trace_line_meta import trace_pkg::*; (
        input  logic                  clk,
        input  logic                  reset,
        input  logic                  clear,
        input  logic                  trace_enable,
        input  logic [3:0]            trace_scale,
        input  pc_t                   pc,
        input  logic                  pc_used,
        input  logic                  rename_stall,
        input  pc_t                   start_pc,
        input  fill_req_t             fill,
        output logic                  start_hit,
        output logic                  free_valid,
        output logic [line_idx_w-1:0] fill_line,
        output line_vec_t             lookup_match,
        output logic                  trace_hit,
        output pc_t                   pc_next
);

        lane_mask_t       valid_mask [num_lines];
        pc_t              tag        [num_lines];
        pc_t              next_pc    [num_lines];
        logic [use_w-1:0] use_cnt    [num_lines];

        logic [8:0] decay_cnt;
        logic       tick;
        logic       wipe;
        line_vec_t  hit_q;                              // lookup hits of the last unstalled cycle
        line_vec_t  fill_sel;
        line_vec_t  start_match;
        line_vec_t  free;

        assign wipe     = clear || !trace_enable;
        assign tick     = decay_cnt == '0;
        assign fill_sel = fill.write ? (line_vec_t'(1) << fill_line) : '0;

        // associative compare against lines whose lane 0 is valid
        always_comb begin
                for (int i = 0; i < num_lines; i++) begin
                        lookup_match[i] = valid_mask[i][0] && tag[i] == pc;
                        start_match[i]  = valid_mask[i][0] && tag[i] == start_pc;
                        free[i]         = use_cnt[i] == '0;
                end
        end

        assign trace_hit = |lookup_match;
        assign start_hit = |start_match;

        always_comb begin
                pc_next = '0;
                for (int i = 0; i < num_lines; i++) begin
                        if (lookup_match[i])
                                pc_next = pc_next | next_pc[i];     // one-hot mux
                end
        end

        // lowest free line wins
        always_comb begin
                free_valid = 1'b0;
                fill_line  = '0;
                for (int i = num_lines - 1; i >= 0; i--) begin
                        if (free[i]) begin
                                free_valid = 1'b1;
                                fill_line  = line_idx_w'(i);
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (reset || tick)
                        decay_cnt <= decay_reload(trace_scale);
                else
                        decay_cnt <= decay_cnt - 9'd1;
        end

        always_ff @(posedge clk) begin
                if (reset || wipe)
                        hit_q <= '0;
                else if (!rename_stall)
                        hit_q <= lookup_match;
        end

        always_ff @(posedge clk) begin
                for (int i = 0; i < num_lines; i++) begin
                        if (reset || wipe)
                                valid_mask[i] <= '0;
                        else if (fill_sel[i])
                                valid_mask[i] <= fill.lanes;

                        if (fill_sel[i]) begin              // tag and next pc of the new line
                                tag[i]     <= fill.tag;
                                next_pc[i] <= fill.next;
                        end

                        if (reset || wipe) begin
                                use_cnt[i] <= '0;
                        end else if (fill_sel[i]) begin
                                if (use_cnt[i] < use_fill)
                                        use_cnt[i] <= use_fill;
                        end else if (hit_q[i] && pc_used) begin
                                if (!tick && use_cnt[i] != use_max)
                                        use_cnt[i] <= use_cnt[i] + 1'b1;
                        end else if (tick && use_cnt[i] != '0) begin
                                use_cnt[i] <= use_cnt[i] - 1'b1;
                        end
                end
        end

        // duplicate start pcs are refused by the fill logic, so tags stay unique
        a_match_onehot: assert property (@(posedge clk) disable iff (reset)
                $onehot0(lookup_match));

        // fill requests only target a line this module offered
        a_fill_free: assert property (@(posedge clk) disable iff (reset)
                fill.write |-> free_valid);

endmodule

//--- trace_data_store.sv
// one read and one write port; lanes outside the stored mask hold stale bundles
`timescale 1ns/10ps

module trace_data_store import trace_pkg::*; (
        input  logic                  clk,
        input  logic                  reset,
        input  logic                  rename_stall,
        input  fill_req_t             fill,
        input  logic [line_idx_w-1:0] fill_line,
        input  trace_group_t          trace_in,
        input  line_vec_t             lookup_match,
        output trace_group_t          trace_out
);

        trace_bundle_t mem      [num_lines][num_lanes];
        lane_mask_t    mem_mask [num_lines];

        trace_bundle_t [num_lanes-1:0] rd_b;
        lane_mask_t                    rd_valid;
        trace_bundle_t [num_lanes-1:0] out_b;
        lane_mask_t                    out_valid;

        // per-lane write strobes into the chosen line
        always_ff @(posedge clk) begin
                if (fill.write) begin
                        mem_mask[fill_line] <= fill.lanes;
                        for (int l = 0; l < num_lanes; l++) begin
                                if (fill.lanes[l])
                                        mem[fill_line][l] <= trace_in.b[l];
                        end
                end
        end

        // one-hot read of the hit line, all zero on a miss
        always_comb begin
                rd_b     = '0;
                rd_valid = '0;
                for (int i = 0; i < num_lines; i++) begin
                        if (lookup_match[i]) begin
                                rd_valid = rd_valid | mem_mask[i];
                                for (int l = 0; l < num_lanes; l++)
                                        rd_b[l] = rd_b[l] | mem[i][l];
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (reset)
                        out_valid <= '0;
                else if (!rename_stall)
                        out_valid <= rd_valid;              // held while rename stalls
        end

        always_ff @(posedge clk) begin
                if (!rename_stall)
                        out_b <= rd_b;
        end

        assign trace_out.valid = out_valid;
        assign trace_out.b     = out_b;

        // the OR mux needs a single selected line whenever it is captured
        a_read_onehot: assert property (@(posedge clk) disable iff (reset)
                !rename_stall |-> $onehot0(lookup_match));

endmodule

//--- trace_cache.sv
// trace cache top; no handshakes, fill is a strobe and rename_stall is the only back-pressure
`timescale 1ns/10ps

module trace_cache import trace_pkg::*; (
        input  logic         clk,
        input  logic         reset,
        input  logic         trace_enable,
        input  logic [3:0]   trace_scale,
        input  logic         invalidate,
        input  logic [3:0]   cpu_mode,
        input  logic         flush,                     // pipe flush, drops the retiring group
        input  pc_t          pc,
        input  logic         pc_used,
        input  logic         rename_stall,
        input  lane_mask_t   will_trap,
        input  trace_group_t trace_in,
        output trace_group_t trace_out,
        output logic         trace_hit,
        output pc_t          pc_next
);

        logic                  clear;
        logic [3:0]            cpu_mode_q;
        pc_t                   start_pc;
        logic                  start_hit;
        logic                  free_valid;
        logic [line_idx_w-1:0] fill_line;
        line_vec_t             lookup_match;
        fill_req_t             fill;

        always_ff @(posedge clk) begin
                cpu_mode_q <= cpu_mode;
                if (reset)
                        clear <= 1'b0;
                else
                        clear <= invalidate || cpu_mode_q != cpu_mode;  // mode change flushes too
        end

        trace_fill_ctrl u_fill_ctrl (
                .trace_in   (trace_in),
                .will_trap  (will_trap),
                .flush      (flush),
                .start_hit  (start_hit),
                .free_valid (free_valid),
                .start_pc   (start_pc),
                .fill       (fill)
        );

        trace_line_meta u_line_meta (
                .clk          (clk),
                .reset        (reset),
                .clear        (clear),
                .trace_enable (trace_enable),
                .trace_scale  (trace_scale),
                .pc           (pc),
                .pc_used      (pc_used),
                .rename_stall (rename_stall),
                .start_pc     (start_pc),
                .fill         (fill),
                .start_hit    (start_hit),
                .free_valid   (free_valid),
                .fill_line    (fill_line),
                .lookup_match (lookup_match),
                .trace_hit    (trace_hit),
                .pc_next      (pc_next)
        );

        trace_data_store u_data_store (
                .clk          (clk),
                .reset        (reset),
                .rename_stall (rename_stall),
                .fill         (fill),
                .fill_line    (fill_line),
                .trace_in     (trace_in),
                .lookup_match (lookup_match),
                .trace_out    (trace_out)
        );

endmodule

//--- tb_trace_cache.sv
// runs at trace_scale 0 with random groups from a fixed seed; lanes outside a trace's mask are not compared
`timescale 1ns/10ps

module tb_trace_cache import trace_pkg::*;;

        localparam int clk_period  = 4;
        localparam int test_cycles = 10 + 30 + 20 + 15 + 25 + 100;   // reset plus the five tests

        logic         clk;
        logic         reset;
        logic         trace_enable;
        logic [3:0]   trace_scale;
        logic         invalidate;
        logic [3:0]   cpu_mode;
        logic         flush;
        pc_t          pc;
        logic         pc_used;
        logic         rename_stall;
        lane_mask_t   will_trap;
        trace_group_t trace_in;
        trace_group_t trace_out;
        logic         trace_hit;
        pc_t          pc_next;

        // reference model state
        lane_mask_t       m_mask [num_lines];
        pc_t              m_tag  [num_lines];
        pc_t              m_next [num_lines];
        logic [use_w-1:0] m_use  [num_lines];
        trace_bundle_t    m_bund [num_lines][num_lanes];
        logic [8:0]       m_decay;
        line_vec_t        m_hitq;
        logic             m_clear;
        logic [3:0]       m_mode_q;
        lane_mask_t       exp_valid;
        trace_bundle_t    exp_b [num_lanes];

        logic [31:0] rng = 32'h0240_b9e7;
        logic        check_on = 1'b0;
        int          errors = 0;
        int          checks = 0;

        trace_cache uut (.*);

        initial clk = 1'b0;
        always #(clk_period / 2) clk = ~clk;

        function automatic logic [31:0] xorshift(input logic [31:0] x);
                x = x ^ (x << 13);
                x = x ^ (x >> 17);
                x = x ^ (x << 5);
                return x;
        endfunction

        function logic [31:0] rnd();
                rng = xorshift(rng);
                return rng;
        endfunction

        // reload value is a run of 4 + scale[3:2] ones with scale[1:0] on top
        function automatic logic [8:0] reload_value(input logic [3:0] s);
                int w;
                w = 4 + s[3:2];
                return 9'((int'(s[1:0]) << w) | ((1 << w) - 1));
        endfunction

        function automatic int model_lookup(input pc_t p);
                for (int i = 0; i < num_lines; i++)
                        if (m_mask[i][0] && m_tag[i] == p)
                                return i;
                return -1;
        endfunction

        function automatic int model_free_line();
                for (int i = 0; i < num_lines; i++)
                        if (m_use[i] == 0)
                                return i;
                return -1;
        endfunction

        // next pc after the last valid lane in halfwords
        function automatic pc_t group_next(input trace_group_t g);
                pc_t n;
                n = '0;
                for (int l = 0; l < num_lanes; l++) begin
                        if (!g.valid[l])
                                continue;
                        if (g.b[l].kind == br_relative)
                                n = pc_t'(g.b[l].pc + g.b[l].immed);
                        else if (g.b[l].kind == br_indirect)
                                n = g.b[l].pc_dest;
                        else
                                n = g.b[l].pc + (g.b[l].short_ins ? 1 : 2);
                end
                return n;
        endfunction

        function automatic bit group_fills(input trace_group_t g, input lane_mask_t trap,
                                           input logic fl);
                int n;
                n = 0;
                while (n < num_lanes && g.valid[n])
                        n++;
                if (n == 0 || g.valid != lane_mask_t'((1 << n) - 1))
                        return 0;                       // empty or holes in the mask
                if ((trap & g.valid) != 0 || fl)
                        return 0;
                return model_lookup(g.b[0].pc) < 0 && model_free_line() >= 0;
        endfunction

        // model steps on the same edge as the DUT from the pre-edge state
        always @(posedge clk) begin
                int         hit;
                int         fl_i;
                bit         fills;
                logic       wipe;
                logic       tick;
                logic [3:0] mode_old;
                hit      = model_lookup(pc);
                fills    = group_fills(trace_in, will_trap, flush);
                fl_i     = model_free_line();
                wipe     = m_clear || !trace_enable;
                tick     = m_decay == 0;
                mode_old = m_mode_q;
                if (reset) begin
                        exp_valid = '0;
                end else if (!rename_stall) begin
                        exp_valid = hit >= 0 ? m_mask[hit] : '0;
                        if (hit >= 0)
                                exp_b = m_bund[hit];
                end
                for (int i = 0; i < num_lines; i++) begin
                        if (reset || wipe)
                                m_use[i] = '0;
                        else if (fills && i == fl_i)
                                m_use[i] = m_use[i] < use_fill ? use_fill : m_use[i];
                        else if (m_hitq[i] && pc_used)
                                m_use[i] = (!tick && m_use[i] != use_max) ?
                                           m_use[i] + 1 : m_use[i];
                        else if (tick && m_use[i] != 0)
                                m_use[i] = m_use[i] - 1;
                end
                if (reset || wipe)
                        m_hitq = '0;
                else if (!rename_stall)
                        m_hitq = hit >= 0 ? line_vec_t'(1) << hit : '0;
                if (fills) begin
                        m_tag[fl_i]  = trace_in.b[0].pc;
                        m_next[fl_i] = group_next(trace_in);
                        m_mask[fl_i] = trace_in.valid;
                        for (int l = 0; l < num_lanes; l++)
                                if (trace_in.valid[l])
                                        m_bund[fl_i][l] = trace_in.b[l];
                end
                for (int i = 0; i < num_lines; i++)
                        if (reset || wipe)
                                m_mask[i] = '0;
                m_decay  = (reset || tick) ? reload_value(trace_scale) : m_decay - 1;
                m_clear  = reset ? 1'b0 : (invalidate || mode_old != cpu_mode);
                m_mode_q = cpu_mode;
        end

        // compare in mid cycle when inputs and outputs have settled
        always @(negedge clk) begin
                int hit;
                if (check_on) begin
                        hit = model_lookup(pc);
                        checks++;
                        assert (trace_hit === (hit >= 0)) else begin
                                $display("ERROR trace_hit exp %h got %h", hit >= 0, trace_hit);
                                errors++;
                        end
                        if (hit >= 0)
                                assert (pc_next === m_next[hit]) else begin
                                        $display("ERROR pc_next exp %h got %h",
                                                 m_next[hit], pc_next);
                                        errors++;
                                end
                        assert (trace_out.valid === exp_valid) else begin
                                $display("ERROR trace_out.valid exp %h got %h",
                                         exp_valid, trace_out.valid);
                                errors++;
                        end
                        for (int l = 0; l < num_lanes; l++)
                                if (exp_valid[l])
                                        assert (trace_out.b[l] === exp_b[l]) else begin
                                                $display("ERROR trace_out.b[%0d] exp %h got %h",
                                                         l, exp_b[l], trace_out.b[l]);
                                                errors++;
                                        end
                end
        end

        task automatic step();
                @(posedge clk);
                #1;
        endtask

        task automatic make_group(output trace_group_t g, input int nl, input branch_kind_e last);
                pc_t p;
                p = pc_t'(rnd());
                g.valid = lane_mask_t'((1 << nl) - 1);
                for (int l = 0; l < num_lanes; l++) begin
                        g.b[l].pc        = p;
                        g.b[l].insn      = rnd();
                        g.b[l].immed     = rnd();
                        g.b[l].short_ins = rnd() % 2;
                        g.b[l].kind      = (l == nl - 1) ? last : br_none;
                        g.b[l].pc_dest   = pc_t'(rnd());
                        p = p + 2;
                end
        endtask

        task automatic retire(input trace_group_t g, input lane_mask_t trap, input logic fl);
                trace_in  = g;
                will_trap = trap;
                flush     = fl;
                step();
                trace_in.valid = '0;
                will_trap      = '0;
                flush          = 1'b0;
        endtask

        task automatic expect_hit(input pc_t p, input logic want, input string what);
                pc = p;
                #0.5;
                checks++;
                assert (trace_hit === want) else begin
                        $display("ERROR trace_hit exp %h got %h (%s)", want, trace_hit, what);
                        errors++;
                end
        endtask

        task automatic report(input string name, input int err0);
                $display("test %s done, %0d errors", name, errors - err0);
        endtask

        task automatic test_fill_hit();
                trace_group_t g;
                int           e0;
                e0 = errors;
                for (int k = 0; k < 6; k++) begin
                        make_group(g, 1 + rnd() % num_lanes, branch_kind_e'(k % 3));
                        retire(g, '0, 1'b0);
                        expect_hit(g.b[0].pc, 1'b1, "fill and hit");
                        step();                         // trace_out checked by the compare process
                end
                report("fill_hit", e0);
        endtask

        task automatic test_discard();
                trace_group_t g;
                trace_group_t d;
                int           e0;
                e0 = errors;
                make_group(g, 3, br_relative);
                retire(g, lane_mask_t'(1 << (rnd() % 3)), 1'b0);
                expect_hit(g.b[0].pc, 1'b0, "trapping group");
                make_group(g, 2, br_none);
                retire(g, '0, 1'b1);
                expect_hit(g.b[0].pc, 1'b0, "flushed group");
                make_group(g, 4, br_indirect);
                g.valid = 4'b0101;
                retire(g, '0, 1'b0);
                expect_hit(g.b[0].pc, 1'b0, "holes in mask");
                make_group(g, 2, br_none);
                retire(g, '0, 1'b0);
                make_group(d, 4, br_indirect);
                d.b[0].pc = g.b[0].pc;                  // same start pc so the original line must stay
                retire(d, '0, 1'b0);
                expect_hit(g.b[0].pc, 1'b1, "repeated start pc");
                step();
                report("discard", e0);
        endtask

        task automatic test_stall();
                trace_group_t a;
                trace_group_t b;
                int           e0;
                e0 = errors;
                invalidate = 1'b1;                      // start empty so both traces get a line
                step();
                invalidate = 1'b0;
                step();
                make_group(a, 4, br_relative);
                make_group(b, 2, br_indirect);
                retire(a, '0, 1'b0);
                retire(b, '0, 1'b0);
                pc = a.b[0].pc;
                step();
                rename_stall = 1'b1;
                pc           = b.b[0].pc;
                repeat (3) begin
                        step();
                        checks++;
                        assert (trace_out === a) else begin
                                $display("ERROR trace_out exp %h got %h", a, trace_out);
                                errors++;
                        end
                end
                rename_stall = 1'b0;
                step();
                checks++;
                assert (trace_out.valid === b.valid) else begin
                        $display("ERROR trace_out.valid exp %h got %h", b.valid, trace_out.valid);
                        errors++;
                end
                for (int l = 0; l < num_lanes; l++)
                        if (b.valid[l])
                                assert (trace_out.b[l] === b.b[l]) else begin
                                        $display("ERROR trace_out.b[%0d] exp %h got %h",
                                                 l, b.b[l], trace_out.b[l]);
                                        errors++;
                                end
                report("stall_hold", e0);
        endtask

        task automatic test_clear();
                trace_group_t g;
                int           e0;
                e0 = errors;
                for (int k = 0; k < 3; k++) begin
                        make_group(g, 2, br_none);
                        retire(g, '0, 1'b0);
                        expect_hit(g.b[0].pc, 1'b1, "fill before clear");
                        case (k)
                        0: invalidate = 1'b1;
                        1: cpu_mode = cpu_mode + 1;
                        default: trace_enable = 1'b0;
                        endcase
                        step();
                        invalidate = 1'b0;
                        step();
                        expect_hit(g.b[0].pc, 1'b0, "after clear");
                        trace_enable = 1'b1;
                        step();
                end
                report("clearing", e0);
        endtask

        task automatic test_replace();
                trace_group_t g [num_lines + 1];
                int           e0;
                e0 = errors;
                for (int k = 0; k <= num_lines; k++)
                        make_group(g[k], 1 + rnd() % num_lanes, branch_kind_e'(rnd() % 3));
                for (int k = 0; k <= num_lines; k++)
                        retire(g[k], '0, 1'b0);
                expect_hit(g[num_lines].b[0].pc, 1'b0, "ninth trace with all lines busy");
                pc      = g[0].b[0].pc;                 // keep line 0 hot
                pc_used = 1'b1;
                repeat (80) step();
                pc_used = 1'b0;
                checks++;
                assert (model_free_line() == 1) else begin
                        $display("decay left no free line, or line 0 was not kept");
                        errors++;
                end
                retire(g[num_lines], '0, 1'b0);
                expect_hit(g[num_lines].b[0].pc, 1'b1, "ninth trace after decay");
                step();
                expect_hit(g[1].b[0].pc, 1'b0, "replaced line 1");
                step();
                expect_hit(g[0].b[0].pc, 1'b1, "hot line 0");
                step();
                expect_hit(g[2].b[0].pc, 1'b1, "line 2");
                step();
                report("replace_decay", e0);
        endtask

        initial begin
                reset        = 1'b1;
                trace_enable = 1'b1;
                trace_scale  = 4'd0;
                invalidate   = 1'b0;
                cpu_mode     = 4'd0;
                flush        = 1'b0;
                pc           = '0;
                pc_used      = 1'b0;
                rename_stall = 1'b0;
                will_trap    = '0;
                trace_in     = '0;
                repeat (10) @(posedge clk);
                #1;
                reset    = 1'b0;
                check_on = 1'b1;
                test_fill_hit();
                test_discard();
                test_stall();
                test_clear();
                test_replace();
                $display("checks %0d, errors %0d", checks, errors);
                if (errors == 0)
                        $display("=== PASS ===");
                else
                        $display("=== FAIL ===");
                $finish;
        end

        // watchdog allows twice the expected run length
        initial begin
                #(test_cycles * 2 * clk_period);
                $display("timeout, the tests did not finish in time");
                $display("=== FAIL ===");
                $finish;
        end

endmodule

//--- flist.f
trace_pkg.sv
trace_fill_ctrl.sv
trace_line_meta.sv
trace_data_store.sv
trace_cache.sv
tb_trace_cache.sv

//--- Bender.yml
package:
  name: trace_cache

sources:
  - trace_pkg.sv
  - trace_fill_ctrl.sv
  - trace_line_meta.sv
  - trace_data_store.sv
  - trace_cache.sv
  - target: simulation
    files:
      - tb_trace_cache.sv
